/* Bender.yml */
package:
  name: conv3x3

sources:
  - logic/conv_pkg.sv
  - logic/cmd_receiver.sv
  - logic/kernel_store.sv
  - logic/row_window_buffer.sv
  - logic/window_mac.sv
  - logic/conv_row_engine.sv
  - logic/result_sender.sv
  - logic/conv3x3_top.sv
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/conv3x3_tb.sv

/* files.f */
logic/conv_pkg.sv
logic/cmd_receiver.sv
logic/kernel_store.sv
logic/row_window_buffer.sv
logic/window_mac.sv
logic/conv_row_engine.sv
logic/result_sender.sv
logic/conv3x3_top.sv
tb/clock_gen.sv
tb/conv3x3_tb.sv

/* logic/cmd_receiver.sv */
`timescale 1ns/1ns
module cmd_receiver #(
	parameter int ROW_PIX = 8
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              i_cmd_req,
	input  conv_pkg::in_op_e                  i_cmd_op,
	input  logic [ROW_PIX*conv_pkg::PIX_W-1:0] i_cmd_data,
	input  logic                              i_row_ready,
	output logic                              o_cmd_ack,
	output logic                              o_wt_lo_wr,
	output logic                              o_wt_hi_wr,
	output logic                              o_row_push,
	output logic                              o_flush,
	output logic [ROW_PIX*conv_pkg::PIX_W-1:0] o_data
);

	logic accept;
	logic is_row;

	assign is_row = (i_cmd_op == conv_pkg::OP_ROW);

	// rows wait for the engine, everything else goes straight through
	assign accept = i_cmd_req && !o_cmd_ack && (!is_row || i_row_ready);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_cmd_ack  <= 1'b0;
			o_wt_lo_wr <= 1'b0;
			o_wt_hi_wr <= 1'b0;
			o_row_push <= 1'b0;
			o_flush    <= 1'b0;
		end else begin
			o_wt_lo_wr <= accept && (i_cmd_op == conv_pkg::OP_WEIGHT_LO);
			o_wt_hi_wr <= accept && (i_cmd_op == conv_pkg::OP_WEIGHT_HI);
			o_row_push <= accept && is_row;
			o_flush    <= accept && (i_cmd_op == conv_pkg::OP_FLUSH);
			if (accept) begin
				o_cmd_ack <= 1'b1;
			end else if (!i_cmd_req) begin
				o_cmd_ack <= 1'b0;  // master released req
			end
		end
	end

	// data word held with the strobe
	always_ff @(posedge clk) begin
		if (accept) begin
			o_data <= i_cmd_data;
		end
	end

endmodule

/* logic/conv3x3_top.sv */
`timescale 1ns/1ns
module conv3x3_top #(
	parameter int ROW_PIX = 8
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  i_cmd_req,
	input  conv_pkg::in_op_e                      i_cmd_op,
	input  logic [ROW_PIX*conv_pkg::PIX_W-1:0]     i_cmd_data,
	input  conv_pkg::stride_e                     i_stride,
	input  logic                                  i_res_ack,
	output logic                                  o_cmd_ack,
	output logic                                  o_res_req,
	output logic [(ROW_PIX-2)*conv_pkg::SUM_W-1:0] o_res_data
);

	localparam int PW    = conv_pkg::PIX_W;
	localparam int RES_W = (ROW_PIX - 2) * conv_pkg::SUM_W;

	logic                       wt_lo_wr, wt_hi_wr, row_push, flush;
	logic [ROW_PIX*PW-1:0]      cmd_word;
	logic [9*PW-1:0]            weights;
	logic [3*ROW_PIX*PW-1:0]    rows;
	logic                       full, row_ready, res_load, sender_idle;
	logic [RES_W-1:0]           result;

	cmd_receiver #(.ROW_PIX(ROW_PIX)) u_cmd (
		.clk(clk), .rst(rst), .i_cmd_req(i_cmd_req), .i_cmd_op(i_cmd_op),
		.i_cmd_data(i_cmd_data), .i_row_ready(row_ready), .o_cmd_ack(o_cmd_ack),
		.o_wt_lo_wr(wt_lo_wr), .o_wt_hi_wr(wt_hi_wr), .o_row_push(row_push),
		.o_flush(flush), .o_data(cmd_word));

	kernel_store u_kernel (
		.clk(clk), .rst(rst), .i_wt_lo_wr(wt_lo_wr), .i_wt_hi_wr(wt_hi_wr),
		.i_data_lo(cmd_word[8*PW-1:0]), .i_data_hi(cmd_word[PW-1:0]), .o_weights(weights));

	row_window_buffer #(.ROW_PIX(ROW_PIX)) u_rows (
		.clk(clk), .rst(rst), .i_row_push(row_push), .i_flush(flush),
		.i_row(cmd_word), .o_rows(rows), .o_full(full));

	conv_row_engine #(.ROW_PIX(ROW_PIX)) u_engine (
		.clk(clk), .rst(rst), .i_row_push(row_push), .i_full(full), .i_rows(rows),
		.i_weights(weights), .i_stride(i_stride), .i_sender_idle(sender_idle),
		.o_row_ready(row_ready), .o_res_load(res_load), .o_result(result));

	result_sender #(.RES_W(RES_W)) u_sender (
		.clk(clk), .rst(rst), .i_res_load(res_load), .i_result(result),
		.i_res_ack(i_res_ack), .o_sender_idle(sender_idle), .o_res_req(o_res_req),
		.o_res_data(o_res_data));

endmodule

/* logic/conv_pkg.sv */
package conv_pkg;

	// pixel and weight width
	localparam int PIX_W = 8;

	// 16 bit product plus growth for nine terms
	localparam int SUM_W = 20;

	// command opcodes
	typedef enum logic [1:0] {
		OP_WEIGHT_LO = 2'd0,  // bytes 0..7 -> weights 0..7
		OP_WEIGHT_HI = 2'd1,  // byte 0 -> weight 8
		OP_ROW       = 2'd2,  // one pixel row
		OP_FLUSH     = 2'd3   // drop row history
	} in_op_e;

	typedef enum logic {
		STRIDE_1 = 1'b0,
		STRIDE_2 = 1'b1
	} stride_e;

	typedef enum logic {
		ENG_EMPTY = 1'b0,  // no result held
		ENG_HOLD  = 1'b1   // result waiting for sender
	} eng_state_e;

endpackage

/* logic/conv_row_engine.sv */
`timescale 1ns/1ns
module conv_row_engine #(
	parameter int ROW_PIX = 8
) (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          i_row_push,
	input  logic                                          i_full,
	input  logic [3*ROW_PIX*conv_pkg::PIX_W-1:0]           i_rows,
	input  logic [9*conv_pkg::PIX_W-1:0]                   i_weights,
	input  conv_pkg::stride_e                             i_stride,
	input  logic                                          i_sender_idle,
	output logic                                          o_row_ready,
	output logic                                          o_res_load,
	output logic [(ROW_PIX-2)*conv_pkg::SUM_W-1:0]         o_result
);

	localparam int SLOTS = ROW_PIX - 2;

	conv_pkg::eng_state_e state;

	logic                                  push_d;   // buffer updated last cycle
	logic                                  compute;
	logic [SLOTS-1:0][conv_pkg::SUM_W-1:0] sums;     // one per left column
	logic [SLOTS-1:0][conv_pkg::SUM_W-1:0] sums_s2;
	logic [SLOTS-1:0][conv_pkg::SUM_W-1:0] slots;

	for (genvar j = 0; j < SLOTS; j++) begin : g_slot
		window_mac #(
			.ROW_PIX (ROW_PIX),
			.COL     (j)
		) u_mac (
			.i_rows    (i_rows),
			.i_weights (i_weights),
			.o_sum     (sums[j])
		);
		if (2*j <= ROW_PIX-3) begin : g_s2
			assign sums_s2[j] = sums[2*j];
		end else begin : g_s2_zero
			assign sums_s2[j] = '0;  // past the last stride-2 window
		end
	end

	assign slots = (i_stride == conv_pkg::STRIDE_1) ? sums : sums_s2;

	assign compute     = push_d && i_full && (state == conv_pkg::ENG_EMPTY);
	assign o_res_load  = (state == conv_pkg::ENG_HOLD) && i_sender_idle;
	// hold off the next row while a push is still on its way in
	assign o_row_ready = !push_d && (state == conv_pkg::ENG_EMPTY || i_sender_idle);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state  <= conv_pkg::ENG_EMPTY;
			push_d <= 1'b0;
		end else begin
			push_d <= i_row_push;
			case (state)
				conv_pkg::ENG_EMPTY: if (compute) state <= conv_pkg::ENG_HOLD;
				conv_pkg::ENG_HOLD:  if (i_sender_idle) state <= conv_pkg::ENG_EMPTY;
				default:             state <= conv_pkg::ENG_EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (compute) begin
			o_result <= slots;
		end
	end

endmodule

/* logic/kernel_store.sv */
`timescale 1ns/1ns
module kernel_store (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          i_wt_lo_wr,
	input  logic                          i_wt_hi_wr,
	input  logic [8*conv_pkg::PIX_W-1:0]  i_data_lo,
	input  logic [conv_pkg::PIX_W-1:0]    i_data_hi,
	output logic [9*conv_pkg::PIX_W-1:0]  o_weights
);

	logic [8*conv_pkg::PIX_W-1:0] w_lo;  // weights 0..7
	logic [conv_pkg::PIX_W-1:0]   w_hi;  // weight 8

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			w_lo <= '0;
		end else if (i_wt_lo_wr) begin
			w_lo <= i_data_lo;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			w_hi <= '0;
		end else if (i_wt_hi_wr) begin
			w_hi <= i_data_hi;
		end
	end

	// weight k in byte k
	assign o_weights = {w_hi, w_lo};

endmodule

/* logic/result_sender.sv */
`timescale 1ns/1ns
module result_sender #(
	parameter int RES_W = 120
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             i_res_load,
	input  logic [RES_W-1:0] i_result,
	input  logic             i_res_ack,
	output logic             o_sender_idle,
	output logic             o_res_req,
	output logic [RES_W-1:0] o_res_data
);

	typedef enum logic [1:0] {
		SND_IDLE = 2'd0,
		SND_REQ  = 2'd1,  // req up, waiting for ack
		SND_WAIT = 2'd2   // req down, waiting for ack to drop
	} snd_state_e;

	snd_state_e state;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= SND_IDLE;
		end else begin
			case (state)
				SND_IDLE: if (i_res_load) state <= SND_REQ;
				SND_REQ:  if (i_res_ack) state <= SND_WAIT;
				SND_WAIT: if (!i_res_ack) state <= SND_IDLE;
				default:  state <= SND_IDLE;
			endcase
		end
	end

	// stays put until the next load
	always_ff @(posedge clk) begin
		if (i_res_load && state == SND_IDLE) begin
			o_res_data <= i_result;
		end
	end

	assign o_sender_idle = (state == SND_IDLE);
	assign o_res_req     = (state == SND_REQ);

endmodule

/* logic/row_window_buffer.sv */
`timescale 1ns/1ns
module row_window_buffer #(
	parameter int ROW_PIX = 8
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                i_row_push,
	input  logic                                i_flush,
	input  logic [ROW_PIX*conv_pkg::PIX_W-1:0]   i_row,
	output logic [3*ROW_PIX*conv_pkg::PIX_W-1:0] o_rows,
	output logic                                o_full
);

	localparam int ROW_W = ROW_PIX * conv_pkg::PIX_W;

	logic [3*ROW_W-1:0] hist;
	logic [1:0]         count;

	// rows held, stops at three
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count <= 2'd0;
		end else if (i_flush) begin
			count <= 2'd0;
		end else if (i_row_push && count != 2'd3) begin
			count <= count + 2'd1;
		end
	end

	// newest row enters at the top, oldest falls out of row 0
	always_ff @(posedge clk) begin
		if (i_row_push) begin
			hist <= {i_row, hist[3*ROW_W-1:ROW_W]};
		end
	end

	assign o_rows = hist;
	assign o_full = (count == 2'd3);

endmodule

/* logic/window_mac.sv */
`timescale 1ns/1ns
module window_mac #(
	parameter int ROW_PIX = 8,
	parameter int COL     = 0
) (
	input  logic [3*ROW_PIX*conv_pkg::PIX_W-1:0] i_rows,
	input  logic [9*conv_pkg::PIX_W-1:0]         i_weights,
	output logic [conv_pkg::SUM_W-1:0]           o_sum
);

	localparam int PW = conv_pkg::PIX_W;

	logic [conv_pkg::SUM_W-1:0] acc;
	logic [PW-1:0]              pix;
	logic [PW-1:0]              wt;

	// row r, column c uses weight 3r+c
	always_comb begin
		acc = '0;
		pix = '0;
		wt  = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				pix = i_rows[(r*ROW_PIX + COL + c)*PW +: PW];
				wt  = i_weights[(3*r + c)*PW +: PW];
				acc = acc + pix * wt;  // product widened to sum width
			end
		end
	end

	assign o_sum = acc;

endmodule

/* tb/clock_gen.sv */
`timescale 1ns/1ns
module clock_gen (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #20 o_clk = ~o_clk;  // 40 ns period
	end

	initial begin
		o_rst = 1'b0;
		repeat (10) @(posedge o_clk);
		@(negedge o_clk);
		o_rst = 1'b1;  // released between edges
	end

endmodule

/* tb/conv3x3_tb.sv */
`timescale 1ns/1ns
module conv3x3_tb;

	localparam int ROW_PIX = 8;
	localparam int PW      = conv_pkg::PIX_W;
	localparam int SW      = conv_pkg::SUM_W;
	localparam int SLOTS   = ROW_PIX - 2;
	localparam int ROW_W   = ROW_PIX * PW;
	localparam int RES_W   = SLOTS * SW;
	localparam int TMO     = 1000;  // cycles allowed per wait

	logic              clk;
	logic              rst;
	logic              cmd_req;
	logic              cmd_ack;
	logic              res_req;
	logic              res_ack;
	conv_pkg::in_op_e  cmd_op;
	conv_pkg::stride_e stride;
	logic [ROW_W-1:0]  cmd_data;
	logic [RES_W-1:0]  res_data;

	conv_pkg::in_op_e  tab_op [0:31];
	conv_pkg::stride_e tab_stride [0:31];
	logic [ROW_W-1:0]  tab_data [0:31];
	int                tab_delay [0:31];    // consumer ack delay
	logic              tab_has_res [0:31];
	logic [RES_W-1:0]  tab_res [0:31];

	int               n_entries, issued, received, errors, timeouts, max_row_wait;
	logic [15:0]      lfsr;
	logic [ROW_W-1:0] hist [0:2];  // model history, oldest first
	int               hist_cnt;
	int               wts [0:8];

	clock_gen u_clk (.o_clk(clk), .o_rst(rst));

	conv3x3_top #(.ROW_PIX(ROW_PIX)) uut (
		.clk(clk), .rst(rst), .i_cmd_req(cmd_req), .i_cmd_op(cmd_op),
		.i_cmd_data(cmd_data), .i_stride(stride), .i_res_ack(res_ack),
		.o_cmd_ack(cmd_ack), .o_res_req(res_req), .o_res_data(res_data));

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task random_row(output logic [ROW_W-1:0] row);
		for (int b = 0; b < ROW_W; b++) begin
			row[b] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic int window_sum(input int col);
		int sum;
		sum = 0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				sum += hist[r][(col + c)*PW +: PW] * wts[3*r + c];
			end
		end
		return sum;
	endfunction

	function automatic logic [RES_W-1:0] model_result(input conv_pkg::stride_e s);
		logic [RES_W-1:0] res;
		int col;
		res = '0;
		for (int j = 0; j < SLOTS; j++) begin
			col = (s == conv_pkg::STRIDE_1) ? j : 2*j;
			if (col <= ROW_PIX - 3) begin
				res[j*SW +: SW] = window_sum(col);
			end
		end
		return res;
	endfunction

	// stores one entry and runs the model over it
	task add_entry(input conv_pkg::in_op_e op, input logic [ROW_W-1:0] data,
			input conv_pkg::stride_e s, input int delay);
		tab_op[n_entries]      = op;
		tab_data[n_entries]    = data;
		tab_stride[n_entries]  = s;
		tab_delay[n_entries]   = delay;
		tab_has_res[n_entries] = 1'b0;
		tab_res[n_entries]     = '0;
		case (op)
			conv_pkg::OP_WEIGHT_LO: begin
				for (int k = 0; k < 8; k++) begin
					wts[k] = data[k*PW +: PW];
				end
			end
			conv_pkg::OP_WEIGHT_HI: wts[8] = data[PW-1:0];
			conv_pkg::OP_FLUSH:     hist_cnt = 0;
			default: begin
				hist[0] = hist[1];
				hist[1] = hist[2];
				hist[2] = data;
				if (hist_cnt < 3) hist_cnt++;
				if (hist_cnt == 3) begin
					tab_has_res[n_entries] = 1'b1;
					tab_res[n_entries]     = model_result(s);
				end
			end
		endcase
		n_entries++;
	endtask

	task send_command(input int i);
		int waited;
		waited   = 0;
		cmd_op   = tab_op[i];
		cmd_data = tab_data[i];
		cmd_req  = 1'b1;
		@(negedge clk);
		while (!cmd_ack && waited < TMO) begin
			@(negedge clk);
			waited++;
		end
		if (!cmd_ack) begin
			$display("timeout: command %0d was never acknowledged", i);
			timeouts++;
		end
		if (tab_op[i] == conv_pkg::OP_ROW && waited > max_row_wait) max_row_wait = waited;
		cmd_req = 1'b0;
		waited  = 0;
		while (cmd_ack && waited < TMO) begin
			@(negedge clk);
			waited++;
		end
		if (cmd_ack) begin
			$display("timeout: command ack stayed high after req dropped, entry %0d", i);
			timeouts++;
		end
	endtask

	task drive_commands;
		int waited;
		for (int i = 0; i < n_entries; i++) begin
			if (tab_stride[i] != stride) begin
				waited = 0;  // results in flight must finish at the old stride
				while (received < issued && waited < TMO) begin
					@(negedge clk);
					waited++;
				end
				if (received < issued) begin
					$display("timeout: results still pending before a stride change");
					timeouts++;
				end
				stride = tab_stride[i];
			end
			send_command(i);
			if (tab_has_res[i]) issued++;
		end
	endtask

	task check_result(input int i);
		for (int j = 0; j < SLOTS; j++) begin
			if (res_data[j*SW +: SW] !== tab_res[i][j*SW +: SW]) begin
				$display("[FAIL] t=%0t o_res_data[%0d] entry %0d: got %0d, expected %0d",
					$time, j, i, res_data[j*SW +: SW], tab_res[i][j*SW +: SW]);
				errors++;
			end
		end
	endtask

	task receive_results;
		int waited;
		for (int i = 0; i < n_entries; i++) begin
			if (tab_has_res[i]) begin
				waited = 0;
				while (!res_req && waited < TMO) begin
					@(negedge clk);
					waited++;
				end
				if (!res_req) begin
					$display("timeout: no result arrived for entry %0d", i);
					timeouts++;
				end else begin
					check_result(i);
					repeat (tab_delay[i]) @(negedge clk);
					res_ack = 1'b1;
					waited  = 0;
					while (res_req && waited < TMO) begin
						@(negedge clk);
						waited++;
					end
					if (res_req) begin
						$display("timeout: result req never dropped for entry %0d", i);
						timeouts++;
					end
					res_ack = 1'b0;
					received++;
				end
			end
		end
	endtask

	initial begin
		logic [ROW_W-1:0] row;
		int waited;
		logic extra;
		cmd_req  = 1'b0;
		cmd_op   = conv_pkg::OP_FLUSH;
		cmd_data = '0;
		stride   = conv_pkg::STRIDE_1;
		res_ack  = 1'b0;
		n_entries    = 0;
		issued       = 0;
		received     = 0;
		errors       = 0;
		timeouts     = 0;
		max_row_wait = 0;
		hist_cnt     = 0;
		lfsr  = 16'd44;
		extra = 1'b0;
		for (int k = 0; k < 3; k++) hist[k] = '0;
		for (int k = 0; k < 9; k++) wts[k] = 0;

		add_entry(conv_pkg::OP_WEIGHT_LO, 64'h07_80_63_00_01_C8_11_FF, conv_pkg::STRIDE_1, 0);
		add_entry(conv_pkg::OP_WEIGHT_HI, 64'hA5A5_A5A5_A5A5_A5FE, conv_pkg::STRIDE_1, 0);
		for (int k = 0; k < 5; k++) begin
			random_row(row);
			add_entry(conv_pkg::OP_ROW, row, conv_pkg::STRIDE_1, k);
		end
		for (int k = 0; k < 2; k++) begin
			random_row(row);
			add_entry(conv_pkg::OP_ROW, row, conv_pkg::STRIDE_2, 1);
		end
		add_entry(conv_pkg::OP_FLUSH, '0, conv_pkg::STRIDE_1, 0);
		for (int k = 0; k < 3; k++) begin
			random_row(row);
			add_entry(conv_pkg::OP_ROW, row, conv_pkg::STRIDE_1, 0);
		end
		for (int k = 0; k < 6; k++) begin
			random_row(row);
			add_entry(conv_pkg::OP_ROW, row, conv_pkg::STRIDE_1, 25);  // slow consumer
		end

		waited = 0;
		while (!rst && waited < TMO) begin
			@(negedge clk);
			waited++;
		end
		if (!rst) begin
			$display("timeout: reset was never released");
			timeouts++;
		end
		repeat (4) begin
			@(negedge clk);
			if (cmd_ack || res_req) begin
				$display("handshake outputs not idle after reset");
				errors++;
			end
		end

		fork
			drive_commands;
			receive_results;
		join

		repeat (20) begin
			@(negedge clk);
			if (res_req) extra = 1'b1;
		end
		if (extra) begin
			$display("an unexpected extra result was offered");
			errors++;
		end
		if (max_row_wait < 5) begin
			$display("row commands were never held back by a busy consumer");
			errors++;
		end
		$display("summary: %0d errors, %0d timeouts, %0d of %0d results received",
			errors, timeouts, received, issued);
		if (errors == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
